// File: list.f
verilog/pipe_pkg.sv
verilog/decoder.sv
verilog/reg_file.sv
verilog/forwarding_unit.sv
verilog/hazard_unit.sv
verilog/exe_stage.sv
verilog/data_mem.sv
verilog/pipeline.sv
bench/tb_pipeline.sv

// File: bench/tb_pipeline.sv
`timescale 1ns/1ps

module tb_pipeline;

   import pipe_pkg::*;

   logic              clk;
   logic              arst_n;
   logic [DATA_W-1:0] imem_addr;
   logic [DATA_W-1:0] imem_data;
   wb_t               wb;

   // Instruction memory, program under test and expected writebacks
   logic [DATA_W-1:0] imem [256];
   logic [DATA_W-1:0] mdmem [DMEM_DEPTH];
   logic [DATA_W-1:0] prog [$];
   wb_t               exp_q [$];

   integer            seed;
   int                errors;
   int                cycles;
   int                limit;
   string             test_name;

   pipeline DUT (
      .clk       (clk),
      .arst_n    (arst_n),
      .imem_addr (imem_addr),
      .imem_data (imem_data),
      .wb        (wb)
   );

   assign imem_data = imem[imem_addr[7:0]];

   initial
      clk = 1'b1;

   always #4 clk = ~clk;

   // Run length bound
   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (limit > 0 && cycles > limit)
      begin
         $display("Timeout after %0d cycles in %s", cycles, test_name);
         $display("%0d errors", errors + 1);
         $display("Test FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Instruction encoding
   ////////////////////////////////////////

   function automatic logic [15:0] reg_word(
      input op_e        op,
      input logic [3:0] rd,
      input logic [3:0] rs,
      input logic [3:0] rt
   );
      return {op, rd, rs, rt};
   endfunction

   function automatic logic [15:0] imm_word(
      input op_e        op,
      input logic [3:0] rd,
      input logic [7:0] imm8
   );
      return {op, rd, imm8};
   endfunction

   // Any leaked fetch retires as LI r15 of its address
   function automatic logic [15:0] fill_word(input logic [7:0] a);
      return {OP_LI, 4'hf, a};
   endfunction

   function automatic logic [7:0] rnd8();
      logic [31:0] v;
      v = $random(seed);
      return v[7:0];
   endfunction

   task automatic emit(input logic [15:0] w);
      prog.push_back(w);
   endtask

   // BEQZ r0 back onto itself
   task automatic halt_here();
      emit(imm_word(OP_BEQZ, 0, 8'hff));
   endtask

   ////////////////////////////////////////
   // Instruction-set model
   ////////////////////////////////////////

   task automatic model_program(output logic [DATA_W-1:0] final_pc, output int n_exec);
      logic [DATA_W-1:0] r [REG_N];
      logic [DATA_W-1:0] pc;
      logic [DATA_W-1:0] instr;
      logic [DATA_W-1:0] w;
      logic [DATA_W-1:0] addr;
      logic [DATA_W-1:0] next_pc;
      logic [3:0]        rd;
      logic [3:0]        rs;
      logic [3:0]        rt;
      logic [7:0]        imm8;
      logic              wr;
      logic              done;
      wb_t               e;
      exp_q.delete();
      for (int i = 0; i < REG_N; i++)
         r[i] = '0;
      pc     = RESET_PC;
      n_exec = 0;
      done   = 1'b0;
      while (!done && n_exec < 2000)
      begin
         instr   = imem[pc[7:0]];
         n_exec  = n_exec + 1;
         rd      = instr[11:8];
         rs      = instr[7:4];
         rt      = instr[3:0];
         imm8    = instr[7:0];
         wr      = 1'b1;
         w       = '0;
         next_pc = pc + 16'd1;
         addr    = r[rs] + {{12{rt[3]}}, rt};
         case (instr[15:12])
            OP_ADD:  w = r[rs] + r[rt];
            OP_SUB:  w = r[rs] - r[rt];
            OP_AND:  w = r[rs] & r[rt];
            OP_OR:   w = r[rs] | r[rt];
            OP_XOR:  w = r[rs] ^ r[rt];
            OP_SLL:  w = r[rs] << r[rt][3:0];
            OP_LI:   w = {8'h00, imm8};
            OP_ADDI: w = r[rd] + {{8{imm8[7]}}, imm8};
            OP_LW:   w = mdmem[addr[7:0]];
            OP_SW:
            begin
               mdmem[addr[7:0]] = r[rd];
               wr = 1'b0;
            end
            OP_BEQZ:
            begin
               wr = 1'b0;
               if (r[rd] == '0)
               begin
                  next_pc = pc + 16'd1 + {{8{imm8[7]}}, imm8};
                  done    = (next_pc == pc);
               end
            end
            OP_JR:
            begin
               next_pc = r[rs];
               wr      = 1'b0;
            end
            default: wr = 1'b0;
         endcase
         // r0 stays zero and never retires
         if (wr && rd != 4'd0)
         begin
            r[rd]  = w;
            e.valid = 1'b1;
            e.rd    = rd;
            e.data  = w;
            exp_q.push_back(e);
         end
         if (!done)
            pc = next_pc;
      end
      if (!done)
      begin
         errors++;
         $display("Reference model never reached the self-loop in %s", test_name);
      end
      final_pc = pc;
   endtask

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   task automatic check_wb(input wb_t got, input wb_t want);
      if (got !== want)
      begin
         errors++;
         $display("FAILED wb in %s: got valid=%h rd=%h data=%h, expected valid=%h rd=%h data=%h",
                  test_name, got.valid, got.rd, got.data, want.valid, want.rd, want.data);
      end
   endtask

   task automatic check_pc(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] want);
      if (got !== want)
      begin
         errors++;
         $display("FAILED imem_addr in %s: got %h expected %h", test_name, got, want);
      end
   endtask

   task automatic sample_wb();
      wb_t want;
      if (wb.valid)
      begin
         if (wb.rd == '0)
         begin
            errors++;
            $display("A write to r0 appeared on wb in %s", test_name);
         end
         else if (exp_q.size() == 0)
         begin
            errors++;
            $display("Unexpected writeback to r%0d in %s", wb.rd, test_name);
         end
         else
         begin
            want = exp_q.pop_front();
            check_wb(wb, want);
         end
      end
   endtask

   task automatic run_program(input string name);
      logic [DATA_W-1:0] final_pc;
      logic [DATA_W-1:0] lowest;
      int                n_exec;
      test_name = name;
      @(negedge clk);
      arst_n = 1'b0;
      for (int a = 0; a < 256; a++)
         imem[a] = (a < prog.size()) ? prog[a] : fill_word(a[7:0]);
      model_program(final_pc, n_exec);
      limit = limit + 6 * n_exec + 60;
      repeat (16)
      begin
         @(negedge clk);
         if (wb.valid !== 1'b0)
         begin
            errors++;
            $display("wb was not held invalid during reset in %s", name);
         end
      end
      arst_n = 1'b1;
      while (exp_q.size() > 0)
      begin
         @(negedge clk);
         sample_wb();
      end
      repeat (20)
      begin
         @(negedge clk);
         sample_wb();
      end
      // Self-loop refetches pc, pc+1, pc+2 while it resolves
      lowest = '1;
      repeat (3)
      begin
         @(negedge clk);
         sample_wb();
         if (imem_addr < lowest)
            lowest = imem_addr;
      end
      check_pc(lowest, final_pc);
      prog.delete();
   endtask

   ////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////

   task automatic alu_ops();
      repeat (2)
      begin
         for (int i = 1; i <= 5; i++)
            emit(imm_word(OP_LI, i[3:0], rnd8()));
         emit(16'h0000);
         emit(16'h0000);
         emit(reg_word(OP_ADD, 6, 1, 2));
         emit(reg_word(OP_SUB, 7, 1, 3));
         emit(reg_word(OP_AND, 8, 2, 3));
         emit(reg_word(OP_OR, 9, 4, 5));
         emit(reg_word(OP_XOR, 10, 1, 5));
         emit(reg_word(OP_SLL, 11, 2, 4));
         emit(imm_word(OP_ADDI, 12, rnd8()));
      end
      halt_here();
      run_program("alu_ops");
   endtask

   task automatic forwarding_chains();
      emit(imm_word(OP_LI, 1, rnd8()));
      emit(imm_word(OP_LI, 2, rnd8()));
      // Distance one and two
      emit(reg_word(OP_ADD, 3, 1, 2));
      emit(reg_word(OP_SUB, 4, 3, 1));
      emit(reg_word(OP_XOR, 5, 3, 4));
      emit(16'h0000);
      emit(reg_word(OP_OR, 6, 5, 3));
      // Distance three goes through the register file
      emit(imm_word(OP_LI, 8, rnd8()));
      emit(16'h0000);
      emit(16'h0000);
      emit(reg_word(OP_ADD, 9, 8, 8));
      emit(imm_word(OP_ADDI, 9, rnd8()));
      emit(imm_word(OP_ADDI, 9, rnd8()));
      emit(reg_word(OP_SLL, 10, 9, 2));
      // Younger producer must win
      emit(imm_word(OP_LI, 12, rnd8()));
      emit(imm_word(OP_LI, 12, rnd8()));
      emit(reg_word(OP_ADD, 13, 12, 0));
      halt_here();
      run_program("forwarding_chains");
   endtask

   task automatic load_store();
      emit(imm_word(OP_LI, 1, rnd8()));
      emit(imm_word(OP_LI, 2, rnd8()));
      emit(imm_word(OP_LI, 13, 8'd8));
      emit(reg_word(OP_SLL, 2, 2, 13));
      emit(imm_word(OP_LI, 14, rnd8()));
      emit(reg_word(OP_OR, 2, 2, 14));
      emit(reg_word(OP_SW, 2, 1, 3));
      emit(reg_word(OP_LW, 3, 1, 3));
      // 0xfe + 5 wraps to address 3
      emit(imm_word(OP_LI, 4, 8'hfe));
      emit(reg_word(OP_SW, 14, 4, 5));
      emit(imm_word(OP_LI, 5, 8'h00));
      emit(reg_word(OP_SW, 2, 5, 4'hf));
      emit(reg_word(OP_LW, 6, 5, 3));
      emit(imm_word(OP_LI, 7, 8'h01));
      emit(reg_word(OP_LW, 8, 7, 4'he));
      // Load-use pairs
      emit(reg_word(OP_LW, 9, 1, 3));
      emit(reg_word(OP_ADD, 10, 9, 9));
      emit(reg_word(OP_LW, 11, 5, 4'hf));
      emit(imm_word(OP_ADDI, 11, 8'h01));
      emit(reg_word(OP_LW, 12, 5, 3));
      emit(reg_word(OP_SW, 12, 12, 7));
      emit(reg_word(OP_LW, 13, 12, 7));
      halt_here();
      run_program("load_store");
   endtask

   task automatic branches();
      emit(imm_word(OP_LI, 1, 8'h05));
      emit(imm_word(OP_BEQZ, 1, 8'h02));
      emit(imm_word(OP_LI, 2, rnd8()));
      emit(imm_word(OP_BEQZ, 0, 8'h02));
      emit(imm_word(OP_LI, 3, 8'h11));
      emit(imm_word(OP_LI, 4, 8'h22));
      emit(imm_word(OP_LI, 5, rnd8()));
      emit(imm_word(OP_ADDI, 1, 8'hfb));
      emit(imm_word(OP_BEQZ, 1, 8'h01));
      emit(imm_word(OP_LI, 6, 8'h33));
      // Countdown loop closed by the backward branch at 13
      emit(imm_word(OP_LI, 12, 8'h03));
      emit(imm_word(OP_ADDI, 12, 8'hff));
      emit(imm_word(OP_BEQZ, 12, 8'h01));
      emit(imm_word(OP_BEQZ, 0, 8'hfd));
      emit(imm_word(OP_LI, 8, 8'd19));
      emit(reg_word(OP_JR, 0, 8, 0));
      emit(imm_word(OP_LI, 9, 8'h44));
      emit(imm_word(OP_LI, 10, 8'h55));
      emit(imm_word(OP_LI, 11, 8'h66));
      emit(imm_word(OP_LI, 7, rnd8()));
      halt_here();
      run_program("branches");
   endtask

   task automatic zero_register();
      emit(16'h0000);
      emit(16'h0000);
      emit(imm_word(OP_LI, 0, 8'h5a));
      emit(imm_word(OP_LI, 1, rnd8()));
      emit(imm_word(OP_LI, 2, rnd8()));
      emit(reg_word(OP_ADD, 0, 1, 2));
      emit(imm_word(OP_ADDI, 0, 8'h7f));
      emit(reg_word(OP_SW, 1, 0, 0));
      emit(reg_word(OP_LW, 0, 0, 0));
      emit(reg_word(OP_ADD, 3, 0, 0));
      emit(reg_word(OP_XOR, 4, 1, 0));
      emit(reg_word(OP_SUB, 5, 0, 2));
      emit(reg_word(OP_LW, 6, 0, 0));
      emit(reg_word(OP_ADD, 7, 6, 0));
      halt_here();
      run_program("zero_register");
   endtask

   initial
   begin
      seed   = 32'hdbf3_371b;
      arst_n = 1'b0;
      errors = 0;
      cycles = 0;
      limit  = 0;
      for (int a = 0; a < 256; a++)
         imem[a] = fill_word(a[7:0]);
      alu_ops();
      forwarding_chains();
      load_store();
      branches();
      zero_register();
      $display("%0d errors", errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// File: verilog/pipeline.sv
`timescale 1ns/1ps

module pipeline (
   input  logic                        clk,
   input  logic                        arst_n,
   output logic [pipe_pkg::DATA_W-1:0] imem_addr,
   input  logic [pipe_pkg::DATA_W-1:0] imem_data,
   output pipe_pkg::wb_t               wb
);

   import pipe_pkg::*;

   typedef struct packed {
      logic              valid;
      logic [DATA_W-1:0] pc;
      logic [DATA_W-1:0] instr;
   } if_id_t;

   // Stage registers
   logic [DATA_W-1:0] pc;
   if_id_t            if_id;
   id_ex_t            id_ex;
   ex_mem_t           ex_mem;
   wb_t               wb_q;
   logic              wb_load;

   // Decode
   logic [DATA_W-1:0] id_instr;
   ctrl_t             dec_ctrl;
   logic [REG_AW-1:0] dec_rd;
   logic [REG_AW-1:0] dec_rs;
   logic [REG_AW-1:0] dec_rt;
   logic [DATA_W-1:0] dec_imm;
   logic              uses_rs;
   logic              uses_rt;
   logic [DATA_W-1:0] rs_val;
   logic [DATA_W-1:0] rt_val;
   id_ex_t            id_ex_d;

   // Execute, hazards, memory
   fwd_e              fwd_rs;
   fwd_e              fwd_rt;
   ex_mem_t           ex_mem_d;
   logic              redirect;
   logic [DATA_W-1:0] target;
   logic              stall;
   logic              flush;
   logic [DATA_W-1:0] dmem_rdata;

   assign imem_addr = pc;

   ////////////////////////////////////////
   // Decode
   ////////////////////////////////////////

   // Empty slot decodes as NOP
   assign id_instr = if_id.valid ? if_id.instr : '0;

   decoder u_decoder (
      .instr   (id_instr),
      .ctrl    (dec_ctrl),
      .rd      (dec_rd),
      .rs_idx  (dec_rs),
      .rt_idx  (dec_rt),
      .imm     (dec_imm),
      .uses_rs (uses_rs),
      .uses_rt (uses_rt)
   );

   reg_file u_reg_file (
      .clk    (clk),
      .arst_n (arst_n),
      .rs_idx (dec_rs),
      .rt_idx (dec_rt),
      .rs_val (rs_val),
      .rt_val (rt_val),
      .wb     (wb)
   );

   assign id_ex_d = '{
      valid:  if_id.valid,
      ctrl:   dec_ctrl,
      pc:     if_id.pc,
      rd:     dec_rd,
      rs_idx: dec_rs,
      rt_idx: dec_rt,
      rs_val: rs_val,
      rt_val: rt_val,
      imm:    dec_imm
   };

   hazard_unit u_hazard_unit (
      .uses_rs  (uses_rs),
      .uses_rt  (uses_rt),
      .rs_idx   (dec_rs),
      .rt_idx   (dec_rt),
      .id_ex    (id_ex),
      .redirect (redirect),
      .stall    (stall),
      .flush    (flush)
   );

   ////////////////////////////////////////
   // Execute and memory
   ////////////////////////////////////////

   forwarding_unit u_forwarding_unit (
      .id_ex  (id_ex),
      .ex_mem (ex_mem),
      .wb     (wb),
      .fwd_rs (fwd_rs),
      .fwd_rt (fwd_rt)
   );

   exe_stage u_exe_stage (
      .id_ex      (id_ex),
      .fwd_rs     (fwd_rs),
      .fwd_rt     (fwd_rt),
      .mem_result (ex_mem.result),
      .wb         (wb),
      .ex_mem     (ex_mem_d),
      .redirect   (redirect),
      .target     (target)
   );

   data_mem u_data_mem (
      .clk   (clk),
      .addr  (ex_mem.addr),
      .wdata (ex_mem.store_data),
      .we    (ex_mem.valid && ex_mem.mem_write),
      .rdata (dmem_rdata)
   );

   ////////////////////////////////////////
   // PC and stage registers
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         pc      <= RESET_PC;
         if_id   <= '0;
         id_ex   <= '0;
         ex_mem  <= '0;
         wb_q    <= '0;
         wb_load <= 1'b0;
      end
      else
      begin
         // Redirect drops the two younger instructions
         if (flush)
         begin
            pc    <= target;
            if_id <= '0;
         end
         else if (!stall)
         begin
            pc    <= pc + 1'b1;
            if_id <= '{valid: 1'b1, pc: pc, instr: imem_data};
         end
         // Bubble on stall or flush
         if (flush || stall)
            id_ex <= '0;
         else
            id_ex <= id_ex_d;
         ex_mem  <= ex_mem_d;
         wb_q    <= '{valid: ex_mem.valid && ex_mem.reg_write,
                      rd:    ex_mem.rd,
                      data:  ex_mem.result};
         wb_load <= ex_mem.mem_read;
      end
   end

   // Load data lands together with the wb register
   assign wb = '{valid: wb_q.valid,
                 rd:    wb_q.rd,
                 data:  wb_load ? dmem_rdata : wb_q.data};

   // The bubble after a load-use stall clears the dependence
   assert property (@(posedge clk) disable iff (!arst_n) stall |=> !stall)
      else $error("pipeline: stall held for two cycles");

endmodule

// File: verilog/data_mem.sv
`timescale 1ns/1ps

module data_mem (
   input  logic                         clk,
   input  logic [pipe_pkg::DMEM_AW-1:0] addr,
   input  logic [pipe_pkg::DATA_W-1:0]  wdata,
   input  logic                         we,
   output logic [pipe_pkg::DATA_W-1:0]  rdata
);

   import pipe_pkg::*;

   logic [DATA_W-1:0] mem [DMEM_DEPTH];

   // Registered read, old data on a same-address write
   always_ff @(posedge clk)
   begin
      if (we)
         mem[addr] <= wdata;
      rdata <= mem[addr];
   end

endmodule

// File: verilog/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
   input  pipe_pkg::id_ex_t            id_ex,
   input  pipe_pkg::fwd_e              fwd_rs,
   input  pipe_pkg::fwd_e              fwd_rt,
   input  logic [pipe_pkg::DATA_W-1:0] mem_result,
   input  pipe_pkg::wb_t               wb,
   output pipe_pkg::ex_mem_t           ex_mem,
   output logic                        redirect,
   output logic [pipe_pkg::DATA_W-1:0] target
);

   import pipe_pkg::*;

   logic [DATA_W-1:0] op_s;
   logic [DATA_W-1:0] op_t;
   logic [DATA_W-1:0] op_b;
   logic [DATA_W-1:0] result;

   function automatic logic [DATA_W-1:0] pick(
      input fwd_e              sel,
      input logic [DATA_W-1:0] reg_val,
      input logic [DATA_W-1:0] mem_val,
      input logic [DATA_W-1:0] wb_val
   );
      case (sel)
         FWD_MEM: return mem_val;
         FWD_WB:  return wb_val;
         default: return reg_val;
      endcase
   endfunction

   ////////////////////////////////////////
   // Operands and ALU
   ////////////////////////////////////////

   assign op_s = pick(fwd_rs, id_ex.rs_val, mem_result, wb.data);
   assign op_t = pick(fwd_rt, id_ex.rt_val, mem_result, wb.data);
   assign op_b = id_ex.ctrl.alu_use_imm ? id_ex.imm : op_t;

   always_comb
   begin
      case (id_ex.ctrl.op)
         OP_ADD:  result = op_s + op_b;
         OP_SUB:  result = op_s - op_b;
         OP_AND:  result = op_s & op_b;
         OP_OR:   result = op_s | op_b;
         OP_XOR:  result = op_s ^ op_b;
         OP_SLL:  result = op_s << op_b[3:0];
         OP_LI:   result = op_b;
         // op_t holds the old rd here
         OP_ADDI: result = op_t + op_b;
         OP_LW, OP_SW:
            result = op_s + op_b;
         default: result = '0;
      endcase
   end

   ////////////////////////////////////////
   // Branch resolution and stage output
   ////////////////////////////////////////

   assign redirect = id_ex.valid &&
                     ((id_ex.ctrl.branch && op_t == '0) || id_ex.ctrl.jump);

   assign target = !id_ex.valid    ? '0 :
                   id_ex.ctrl.jump ? op_s : id_ex.pc + 1'b1 + id_ex.imm;

   always_comb
   begin
      ex_mem = '0;
      if (id_ex.valid)
      begin
         ex_mem.valid      = 1'b1;
         ex_mem.reg_write  = id_ex.ctrl.reg_write;
         ex_mem.mem_read   = id_ex.ctrl.mem_read;
         ex_mem.mem_write  = id_ex.ctrl.mem_write;
         ex_mem.rd         = id_ex.rd;
         ex_mem.result     = result;
         ex_mem.store_data = op_t;
         ex_mem.addr       = result[DMEM_AW-1:0];
      end
   end

endmodule

// File: verilog/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
   input  logic                        uses_rs,
   input  logic                        uses_rt,
   input  logic [pipe_pkg::REG_AW-1:0] rs_idx,
   input  logic [pipe_pkg::REG_AW-1:0] rt_idx,
   input  pipe_pkg::id_ex_t            id_ex,
   input  logic                        redirect,
   output logic                        stall,
   output logic                        flush
);

   import pipe_pkg::*;

   logic load_in_ex;
   logic rs_hit;
   logic rt_hit;

   // Load that actually writes a register
   assign load_in_ex = id_ex.valid && id_ex.ctrl.mem_read && id_ex.ctrl.reg_write;

   assign rs_hit = uses_rs && (rs_idx == id_ex.rd);
   assign rt_hit = uses_rt && (rt_idx == id_ex.rd);

   assign flush = redirect;

   // Instruction in decode is discarded on a redirect anyway
   assign stall = load_in_ex && (rs_hit || rt_hit) && !redirect;

endmodule

// File: verilog/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit (
   input  pipe_pkg::id_ex_t  id_ex,
   input  pipe_pkg::ex_mem_t ex_mem,
   input  pipe_pkg::wb_t     wb,
   output pipe_pkg::fwd_e    fwd_rs,
   output pipe_pkg::fwd_e    fwd_rt
);

   import pipe_pkg::*;

   // Youngest producer wins, r0 never forwards
   function automatic fwd_e select_src(
      input logic [REG_AW-1:0] idx,
      input ex_mem_t           mem_stage,
      input wb_t               wb_stage
   );
      if (idx == '0)
         return FWD_REG;
      if (mem_stage.valid && mem_stage.reg_write && mem_stage.rd == idx)
         return FWD_MEM;
      if (wb_stage.valid && wb_stage.rd == idx)
         return FWD_WB;
      return FWD_REG;
   endfunction

   assign fwd_rs = select_src(id_ex.rs_idx, ex_mem, wb);
   assign fwd_rt = select_src(id_ex.rt_idx, ex_mem, wb);

   // Load data is not ready in the memory stage; the load-use
   // stall must have put a bubble between the load and its user
   assert #0 (!(ex_mem.mem_read && (fwd_rs == FWD_MEM || fwd_rt == FWD_MEM)))
      else $error("forwarding: operand taken from a load in memory stage");

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic [pipe_pkg::REG_AW-1:0] rs_idx,
   input  logic [pipe_pkg::REG_AW-1:0] rt_idx,
   output logic [pipe_pkg::DATA_W-1:0] rs_val,
   output logic [pipe_pkg::DATA_W-1:0] rt_val,
   input  pipe_pkg::wb_t               wb
);

   import pipe_pkg::*;

   logic [DATA_W-1:0] regs [REG_N];

   // r0 reads zero, the register being written reads the new value
   function automatic logic [DATA_W-1:0] read_port(
      input logic [REG_AW-1:0] idx,
      input wb_t               w,
      input logic [DATA_W-1:0] stored
   );
      if (idx == '0)
         return '0;
      if (w.valid && w.rd == idx)
         return w.data;
      return stored;
   endfunction

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < REG_N; i++)
            regs[i] <= '0;
      end
      else if (wb.valid && wb.rd != '0)
         regs[wb.rd] <= wb.data;
   end

   assign rs_val = read_port(rs_idx, wb, regs[rs_idx]);
   assign rt_val = read_port(rt_idx, wb, regs[rt_idx]);

endmodule

// File: verilog/decoder.sv
`timescale 1ns/1ps

module decoder (
   input  logic [pipe_pkg::DATA_W-1:0] instr,
   output pipe_pkg::ctrl_t             ctrl,
   output logic [pipe_pkg::REG_AW-1:0] rd,
   output logic [pipe_pkg::REG_AW-1:0] rs_idx,
   output logic [pipe_pkg::REG_AW-1:0] rt_idx,
   output logic [pipe_pkg::DATA_W-1:0] imm,
   output logic                        uses_rs,
   output logic                        uses_rt
);

   import pipe_pkg::*;

   logic [REG_AW-1:0] f_rs;
   logic [REG_AW-1:0] f_rt;
   logic [7:0]        imm8;
   logic              rd_as_rt;

   assign rd   = instr[11:8];
   assign f_rs = instr[7:4];
   assign f_rt = instr[3:0];
   assign imm8 = instr[7:0];

   always_comb
   begin
      ctrl     = '0;
      imm      = '0;
      uses_rs  = 1'b0;
      uses_rt  = 1'b0;
      rd_as_rt = 1'b0;
      case (instr[15:12])
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL:
         begin
            ctrl.op        = op_e'(instr[15:12]);
            ctrl.reg_write = 1'b1;
            uses_rs        = 1'b1;
            uses_rt        = 1'b1;
         end
         OP_LI:
         begin
            ctrl.op          = OP_LI;
            ctrl.alu_use_imm = 1'b1;
            ctrl.reg_write   = 1'b1;
            imm              = {{(DATA_W-8){1'b0}}, imm8};
         end
         OP_ADDI:
         begin
            ctrl.op          = OP_ADDI;
            ctrl.alu_use_imm = 1'b1;
            ctrl.reg_write   = 1'b1;
            uses_rt          = 1'b1;
            rd_as_rt         = 1'b1;
            imm              = {{(DATA_W-8){imm8[7]}}, imm8};
         end
         OP_LW:
         begin
            ctrl.op          = OP_LW;
            ctrl.alu_use_imm = 1'b1;
            ctrl.mem_read    = 1'b1;
            ctrl.reg_write   = 1'b1;
            uses_rs          = 1'b1;
            imm              = {{(DATA_W-4){instr[3]}}, instr[3:0]};
         end
         OP_SW:
         begin
            ctrl.op          = OP_SW;
            ctrl.alu_use_imm = 1'b1;
            ctrl.mem_write   = 1'b1;
            uses_rs          = 1'b1;
            uses_rt          = 1'b1;
            rd_as_rt         = 1'b1;
            imm              = {{(DATA_W-4){instr[3]}}, instr[3:0]};
         end
         OP_BEQZ:
         begin
            ctrl.op     = OP_BEQZ;
            ctrl.branch = 1'b1;
            uses_rt     = 1'b1;
            rd_as_rt    = 1'b1;
            imm         = {{(DATA_W-8){imm8[7]}}, imm8};
         end
         OP_JR:
         begin
            ctrl.op   = OP_JR;
            ctrl.jump = 1'b1;
            uses_rs   = 1'b1;
         end
         default:
         begin
            ctrl.op = OP_NOP;
         end
      endcase
      // r0 is never written
      if (rd == '0)
         ctrl.reg_write = 1'b0;
   end

   // Unused read ports point at r0 so they never match a producer
   assign rs_idx = uses_rs ? f_rs : '0;
   assign rt_idx = !uses_rt ? '0 : (rd_as_rt ? rd : f_rt);

   assert #0 (!(ctrl.mem_read && ctrl.mem_write))
      else $error("decoder: load and store set together");

endmodule

// File: verilog/pipe_pkg.sv
package pipe_pkg;

   ////////////////////////////////////////
   // Sizes
   ////////////////////////////////////////

   localparam int DATA_W     = 16;
   localparam int REG_N      = 16;
   localparam int DMEM_DEPTH = 256;
   localparam int REG_AW     = $clog2(REG_N);
   localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

   localparam logic [DATA_W-1:0] RESET_PC = '0;

   ////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////

   // Opcode in instr[15:12], codes 13..15 unused
   typedef enum logic [3:0] {
      OP_NOP  = 4'h0,
      OP_ADD  = 4'h1,
      OP_SUB  = 4'h2,
      OP_AND  = 4'h3,
      OP_OR   = 4'h4,
      OP_XOR  = 4'h5,
      OP_SLL  = 4'h6,
      OP_LI   = 4'h7,
      OP_ADDI = 4'h8,
      OP_LW   = 4'h9,
      OP_SW   = 4'ha,
      OP_BEQZ = 4'hb,
      OP_JR   = 4'hc
   } op_e;

   // Operand source in execute
   typedef enum logic [1:0] {
      FWD_REG = 2'd0,
      FWD_MEM = 2'd1,
      FWD_WB  = 2'd2
   } fwd_e;

   ////////////////////////////////////////
   // Stage structs
   ////////////////////////////////////////

   typedef struct packed {
      op_e  op;
      logic alu_use_imm;
      logic mem_read;
      logic mem_write;
      logic reg_write;
      logic branch;
      logic jump;
   } ctrl_t;

   typedef struct packed {
      logic              valid;
      ctrl_t             ctrl;
      logic [DATA_W-1:0] pc;
      logic [REG_AW-1:0] rd;
      logic [REG_AW-1:0] rs_idx;
      logic [REG_AW-1:0] rt_idx;
      logic [DATA_W-1:0] rs_val;
      logic [DATA_W-1:0] rt_val;
      logic [DATA_W-1:0] imm;
   } id_ex_t;

   typedef struct packed {
      logic               valid;
      logic               reg_write;
      logic               mem_read;
      logic               mem_write;
      logic [REG_AW-1:0]  rd;
      logic [DATA_W-1:0]  result;
      logic [DATA_W-1:0]  store_data;
      logic [DMEM_AW-1:0] addr;
   } ex_mem_t;

   // Retiring register write
   typedef struct packed {
      logic              valid;
      logic [REG_AW-1:0] rd;
      logic [DATA_W-1:0] data;
   } wb_t;

endpackage
